/* include/whitening_config.svh */
`ifndef WHITENING_CONFIG_SVH
`define WHITENING_CONFIG_SVH

// Q32.32 fixed point
`define FIX_WIDTH 64
`define FIX_FRAC 32

// enabled cycles from eigenvalue to D^-1/2 entry
`define COND_LATENCY 3

// enabled cycles from enable to a valid W
`define WHITEN_LATENCY 4

`endif

/* source/whitening_pkg.sv */
package whitening_pkg;

`include "whitening_config.svh"

        typedef logic signed [`FIX_WIDTH-1:0] fixed_t;   // signed Q32.32
        typedef logic [`FIX_WIDTH-1:0] ufixed_t;         // unsigned Q32.32 magnitude

        // one matrix row, c1 is the leftmost column
        typedef struct packed {
                fixed_t c1;
                fixed_t c2;
                fixed_t c3;
                fixed_t c4;
        } vec4_t;

        typedef struct packed {
                vec4_t r1;
                vec4_t r2;
                vec4_t r3;
                vec4_t r4;
        } mat4_t;

        // diagonal entries only
        typedef struct packed {
                fixed_t d1;
                fixed_t d2;
                fixed_t d3;
                fixed_t d4;
        } diag4_t;

        typedef enum logic [1:0] {
                idle,
                fill,
                run
        } cond_state_t;

endpackage

/* source/fixed_reciprocal.sv */
`timescale 1ns/1ps
`include "whitening_config.svh"

module fixed_reciprocal import whitening_pkg::*; (
        input  fixed_t den,
        output fixed_t quot
);

        localparam int wide = 2 * `FIX_WIDTH;
        localparam logic signed [wide-1:0] one_fix = wide'(1) << `FIX_FRAC;
        localparam fixed_t max_pos = {1'b0, {(`FIX_WIDTH-1){1'b1}}};

        logic signed [wide-1:0] num;
        logic signed [wide-1:0] den_wide;
        logic signed [wide-1:0] q_wide;

        // one pre-shifted by the fraction width so the quotient lands in Q32.32
        assign num      = one_fix <<< `FIX_FRAC;
        assign den_wide = den;   // sign extended

        always_comb begin
                q_wide = '0;
                if (den == '0) begin
                        quot = max_pos;   // saturate instead of dividing by zero
                end else begin
                        q_wide = num / den_wide;
                        quot   = q_wide[`FIX_WIDTH-1:0];
                end
        end

endmodule

/* source/fixed_sqrt.sv */
`timescale 1ns/1ps
`include "whitening_config.svh"

module fixed_sqrt import whitening_pkg::*; (
        input  ufixed_t radicand,
        output ufixed_t root
);

        // radicand scaled by 2^frac so the integer root is already Q32.32
        localparam int op_w  = `FIX_WIDTH + `FIX_FRAC;
        localparam int steps = op_w / 2;

        always_comb begin
                logic [op_w-1:0] rem;
                logic [op_w-1:0] res;
                logic [op_w-1:0] probe;

                rem   = {radicand, {`FIX_FRAC{1'b0}}};
                res   = '0;
                probe = {2'b01, {(op_w-2){1'b0}}};   // highest power of four

                // one result bit per step, restore when the trial subtract fails
                for (int i = 0; i < steps; i++) begin
                        if (rem >= res + probe) begin
                                rem = rem - (res + probe);
                                res = (res >> 1) + probe;
                        end else begin
                                res = res >> 1;
                        end
                        probe = probe >> 2;
                end

                root = res[`FIX_WIDTH-1:0];   // truncated
        end

endmodule

/* source/eigen_conditioning_block.sv */
`timescale 1ns/1ps
`include "whitening_config.svh"

module eigen_conditioning_block import whitening_pkg::*; (
        input  logic   CLK_eig,
        input  logic   reset,
        input  logic   en,
        input  mat4_t  evec,
        input  mat4_t  eval,
        output mat4_t  evec_t,
        output mat4_t  d_inv_sqrt,
        output diag4_t dinv_diag,
        output logic   cond_valid
);

        fixed_t      eig [4];         // eigenvalues off the diagonal of eval
        fixed_t      recip_den [4];   // stage 1
        fixed_t      recip_q [4];
        ufixed_t     sqrt_rad [4];    // stage 2
        ufixed_t     sqrt_root [4];
        fixed_t      diag_q [4];      // stage 3
        cond_state_t state;
        cond_state_t state_nxt;
        logic [1:0]  fill_cnt;

        function automatic mat4_t transpose4(mat4_t m);
                mat4_t t;
                t.r1 = '{m.r1.c1, m.r2.c1, m.r3.c1, m.r4.c1};
                t.r2 = '{m.r1.c2, m.r2.c2, m.r3.c2, m.r4.c2};
                t.r3 = '{m.r1.c3, m.r2.c3, m.r3.c3, m.r4.c3};
                t.r4 = '{m.r1.c4, m.r2.c4, m.r3.c4, m.r4.c4};
                return t;
        endfunction

        assign eig[0] = eval.r1.c1;
        assign eig[1] = eval.r2.c2;
        assign eig[2] = eval.r3.c3;
        assign eig[3] = eval.r4.c4;

        // one divider and one square root per eigenvalue
        for (genvar k = 0; k < 4; k++) begin : g_lane
                fixed_reciprocal u_recip (
                        .den  (recip_den[k]),
                        .quot (recip_q[k])
                );
                fixed_sqrt u_sqrt (
                        .radicand (sqrt_rad[k]),
                        .root     (sqrt_root[k])
                );
        end

        always_ff @(posedge CLK_eig) begin
                if (reset || !en) begin
                        evec_t <= '0;
                        for (int k = 0; k < 4; k++) begin
                                recip_den[k] <= '0;
                                sqrt_rad[k]  <= '0;
                                diag_q[k]    <= '0;
                        end
                end else begin
                        evec_t <= transpose4(evec);
                        for (int k = 0; k < 4; k++) begin
                                recip_den[k] <= eig[k];
                                sqrt_rad[k]  <= ufixed_t'(recip_q[k]);   // 1/d is positive
                                diag_q[k]    <= fixed_t'(sqrt_root[k]);
                        end
                end
        end

        // fill stays two enabled cycles while the pipeline primes
        always_comb begin
                state_nxt = state;
                case (state)
                        idle: state_nxt = fill;
                        fill: begin
                                if (fill_cnt == 2'(`COND_LATENCY - 2))
                                        state_nxt = run;
                        end
                        run: state_nxt = run;
                        default: state_nxt = idle;
                endcase
        end

        always_ff @(posedge CLK_eig) begin
                if (reset || !en) begin
                        state    <= idle;
                        fill_cnt <= '0;
                end else begin
                        state    <= state_nxt;
                        fill_cnt <= (state == fill) ? fill_cnt + 2'd1 : 2'd0;
                end
        end

        assign cond_valid = (state == run);

        always_comb begin
                dinv_diag = '0;
                if (cond_valid) begin   // stale pipeline contents stay hidden
                        dinv_diag.d1 = diag_q[0];
                        dinv_diag.d2 = diag_q[1];
                        dinv_diag.d3 = diag_q[2];
                        dinv_diag.d4 = diag_q[3];
                end
                d_inv_sqrt      = '0;
                d_inv_sqrt.r1.c1 = dinv_diag.d1;
                d_inv_sqrt.r2.c2 = dinv_diag.d2;
                d_inv_sqrt.r3.c3 = dinv_diag.d3;
                d_inv_sqrt.r4.c4 = dinv_diag.d4;
        end

        // run only after three enabled edges in a row
        a_no_valid_after_disable: assert property (@(posedge CLK_eig)
                cond_valid |-> $past(en && !reset, 1) && $past(en && !reset, 2) &&
                        $past(en && !reset, 3))
                else $error("cond_valid high without three enabled cycles before it");

endmodule

/* source/whitening_matrix_unit.sv */
`timescale 1ns/1ps
`include "whitening_config.svh"

module whitening_matrix_unit import whitening_pkg::*; (
        input  logic   CLK_eig,
        input  logic   reset,
        input  logic   en,
        input  mat4_t  evec_t,
        input  diag4_t dinv_diag,
        input  logic   cond_valid,
        output mat4_t  w,
        output logic   valid
);

        // Q32.32 product, full width then truncated back
        function automatic fixed_t fx_mul(fixed_t a, fixed_t b);
                logic signed [2*`FIX_WIDTH-1:0] prod;
                prod = a * b;
                return prod[`FIX_FRAC +: `FIX_WIDTH];
        endfunction

        function automatic vec4_t scale_row(vec4_t r, fixed_t d);
                vec4_t s;
                s.c1 = fx_mul(r.c1, d);
                s.c2 = fx_mul(r.c2, d);
                s.c3 = fx_mul(r.c3, d);
                s.c4 = fx_mul(r.c4, d);
                return s;
        endfunction

        always_ff @(posedge CLK_eig) begin
                if (reset || !en) begin
                        w     <= '0;
                        valid <= 1'b0;
                end else begin
                        // row i of E^T times D^-1/2 entry i
                        w.r1  <= scale_row(evec_t.r1, dinv_diag.d1);
                        w.r2  <= scale_row(evec_t.r2, dinv_diag.d2);
                        w.r3  <= scale_row(evec_t.r3, dinv_diag.d3);
                        w.r4  <= scale_row(evec_t.r4, dinv_diag.d4);
                        valid <= cond_valid;
                end
        end

        // relies on the conditioning block masking its diagonal until run
        a_w_zero_when_invalid: assert property (@(posedge CLK_eig) !valid |-> (w == '0))
                else $error("w nonzero while valid is low");

endmodule

/* source/whitening_top.sv */
`timescale 1ns/1ps

module whitening_top import whitening_pkg::*; (
        input  logic  CLK_eig,
        input  logic  reset,
        input  logic  en,
        input  mat4_t evec,
        input  mat4_t eval,
        output mat4_t evec_t,
        output mat4_t d_inv_sqrt,
        output mat4_t w,
        output logic  valid
);

        diag4_t dinv_diag;
        logic   cond_valid;

        eigen_conditioning_block u_cond (
                .CLK_eig    (CLK_eig),
                .reset      (reset),
                .en         (en),
                .evec       (evec),
                .eval       (eval),
                .evec_t     (evec_t),
                .d_inv_sqrt (d_inv_sqrt),
                .dinv_diag  (dinv_diag),
                .cond_valid (cond_valid)
        );

        whitening_matrix_unit u_wmu (
                .CLK_eig    (CLK_eig),
                .reset      (reset),
                .en         (en),
                .evec_t     (evec_t),
                .dinv_diag  (dinv_diag),
                .cond_valid (cond_valid),
                .w          (w),
                .valid      (valid)
        );

endmodule

/* tests/tb_whitening_checks.sv */
`timescale 1ns/1ps
`include "whitening_config.svh"

module tb_whitening_checks import whitening_pkg::*; (
        input logic  CLK_eig,
        input logic  reset,
        input logic  en,
        input mat4_t evec,
        input mat4_t eval,
        input mat4_t evec_t,
        input mat4_t d_inv_sqrt,
        input mat4_t w,
        input logic  valid
);

        int    run_len = -1;      // enabled edges since the last clear and -1 before the first
        int    fail_count = 0;
        mat4_t evec_q;
        mat4_t eval_q;
        logic  evt_ok;
        logic  diag_ok;
        logic  w_ok;
        logic  valid_ok;

        // element (i,j) with row i and column j counted from zero
        function automatic fixed_t mat_elem(mat4_t m, int i, int j);
                logic [1023:0] flat;
                flat = m;
                return flat[(15 - 4*i - j)*64 +: 64];
        endfunction

        function automatic real to_real(fixed_t x);
                return real'(x) / (2.0 ** `FIX_FRAC);
        endfunction

        function automatic real magnitude(real x);
                return (x < 0.0) ? -x : x;
        endfunction

        task automatic report_error(string msg);
                fail_count++;
                $error("Mismatch at %0t ns: %s", $time, msg);
        endtask

        always @(posedge CLK_eig) begin
                evec_q <= evec;   // inputs as the DUT saw them on this edge
                eval_q <= eval;
                if (reset || !en)
                        run_len <= 0;
                else if (run_len < 100)
                        run_len <= run_len + 1;
        end

        always_comb begin
                real d_exp;
                real w_exp;
                evt_ok  = 1'b1;
                diag_ok = 1'b1;
                w_ok    = 1'b1;
                for (int i = 0; i < 4; i++) begin
                        d_exp = 1.0 / $sqrt(to_real(mat_elem(eval_q, i, i)));
                        for (int j = 0; j < 4; j++) begin
                                if (run_len >= 1) begin
                                        if (mat_elem(evec_t, i, j) != mat_elem(evec_q, j, i))
                                                evt_ok = 1'b0;
                                end else if (mat_elem(evec_t, i, j) != '0) begin
                                        evt_ok = 1'b0;
                                end
                                if (i != j && mat_elem(d_inv_sqrt, i, j) != '0)
                                        diag_ok = 1'b0;   // off diagonal always zero
                                w_exp = to_real(mat_elem(evec_q, j, i)) * d_exp;
                                if (run_len >= `WHITEN_LATENCY) begin
                                        if (magnitude(to_real(mat_elem(w, i, j)) - w_exp) >
                                            2.0 ** -18)
                                                w_ok = 1'b0;
                                end else if (mat_elem(w, i, j) != '0) begin
                                        w_ok = 1'b0;
                                end
                        end
                        if (run_len >= `COND_LATENCY) begin
                                if (magnitude(to_real(mat_elem(d_inv_sqrt, i, i)) - d_exp) >
                                    d_exp * (2.0 ** -20))
                                        diag_ok = 1'b0;
                        end else if (mat_elem(d_inv_sqrt, i, i) != '0) begin
                                diag_ok = 1'b0;
                        end
                end
                valid_ok = (valid == (run_len >= `WHITEN_LATENCY));
        end

        a_evec_t: assert property (@(posedge CLK_eig) run_len >= 0 |-> evt_ok)
                else report_error("evec_t differs from the transpose of evec");
        a_diag: assert property (@(posedge CLK_eig) run_len >= 0 |-> diag_ok)
                else report_error("d_inv_sqrt differs from 1/sqrt of the eigenvalues");
        a_w: assert property (@(posedge CLK_eig) run_len >= 0 |-> w_ok)
                else report_error("w differs from D^-1/2 times E^T");
        a_valid: assert property (@(posedge CLK_eig) run_len >= 0 |-> valid_ok)
                else report_error("valid at the wrong cycle");

endmodule

/* tests/tb_whitening_top.sv */
`timescale 1ns/1ps
`include "whitening_config.svh"

module tb_whitening_top import whitening_pkg::*; ();

        localparam int max_wait = 20;

        logic        CLK_eig = 1'b0;
        logic        reset;
        logic        en;
        mat4_t       evec;
        mat4_t       eval;
        mat4_t       evec_t;
        mat4_t       d_inv_sqrt;
        mat4_t       w;
        logic        valid;
        logic [63:0] rng_state = 64'd57;

        always #2 CLK_eig = ~CLK_eig;

        whitening_top UUT (
                .CLK_eig    (CLK_eig),
                .reset      (reset),
                .en         (en),
                .evec       (evec),
                .eval       (eval),
                .evec_t     (evec_t),
                .d_inv_sqrt (d_inv_sqrt),
                .w          (w),
                .valid      (valid)
        );

        bind whitening_top tb_whitening_checks u_checks (
                .CLK_eig    (CLK_eig),
                .reset      (reset),
                .en         (en),
                .evec       (evec),
                .eval       (eval),
                .evec_t     (evec_t),
                .d_inv_sqrt (d_inv_sqrt),
                .w          (w),
                .valid      (valid)
        );

        function automatic logic [63:0] next_rand();
                logic [63:0] x;
                x = rng_state;
                x = x ^ (x << 13);
                x = x ^ (x >> 7);
                x = x ^ (x << 17);
                rng_state = x;
                return x;
        endfunction

        function automatic mat4_t rand_evec();
                logic [1023:0] flat;
                logic [63:0]   r;
                for (int k = 0; k < 16; k++) begin
                        r = next_rand();
                        flat[k*64 +: 64] = {{32{r[63]}}, r[31:1], 1'b1};   // |x| < 1
                end
                return flat;
        endfunction

        function automatic mat4_t rand_eval();
                logic [1023:0] flat;
                logic [63:0]   r;
                for (int k = 0; k < 16; k++)
                        flat[k*64 +: 64] = next_rand();   // off-diagonal junk
                for (int i = 0; i < 4; i++) begin
                        r = next_rand();
                        // between 1/16 and 4096
                        flat[(15 - 5*i)*64 +: 64] = 64'h1000_0000 +
                                r % (64'h1000_0000_0000 - 64'h1000_0000);
                end
                return flat;
        endfunction

        task automatic next_cycle();
                @(posedge CLK_eig);
                #1;
        endtask

        task automatic wait_for_valid();
                int n;
                n = 0;
                while (!valid && n < max_wait) begin
                        next_cycle();
                        n++;
                end
                if (!valid) begin
                        $display("valid did not rise within %0d cycles of enable", max_wait);
                        $display("=== FAIL ===");
                        $fatal(1, "timeout");
                end
        endtask

        always @(UUT.u_checks.fail_count) begin
                if (UUT.u_checks.fail_count != 0) begin
                        $display("=== FAIL ===");
                        $fatal(1, "stopped at the first error");
                end
        end

        initial begin
                int short_len;
                int hold_len;
                reset = 1'b1;
                en    = 1'b1;   // reset has to win over enable
                evec  = rand_evec();
                eval  = rand_eval();
                repeat (2) next_cycle();
                reset = 1'b0;
                en    = 1'b0;
                next_cycle();
                for (int s = 0; s < 20; s++) begin
                        evec = rand_evec();
                        eval = rand_eval();
                        if (next_rand() % 3 == 0) begin
                                short_len = 1 + int'(next_rand() % 3);   // drops before valid
                                en = 1'b1;
                                repeat (short_len) next_cycle();
                                en = 1'b0;
                                next_cycle();
                        end
                        en = 1'b1;
                        wait_for_valid();
                        if (s == 10) begin
                                reset = 1'b1;   // mid-run reset with en held high
                                next_cycle();
                                reset = 1'b0;
                                wait_for_valid();
                        end
                        hold_len = int'(next_rand() % 6);
                        repeat (hold_len) next_cycle();
                        en = 1'b0;
                        repeat (2) next_cycle();
                end
                if (UUT.u_checks.fail_count == 0) begin
                        $display("=== PASS ===");
                        $finish;
                end else begin
                        $display("=== FAIL ===");
                        $fatal(1, "errors were reported");
                end
        end

endmodule

/* whitening_top.f */
+incdir+include
source/whitening_pkg.sv
source/fixed_reciprocal.sv
source/fixed_sqrt.sv
source/eigen_conditioning_block.sv
source/whitening_matrix_unit.sv
source/whitening_top.sv
tests/tb_whitening_checks.sv
tests/tb_whitening_top.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_whitening_top \
        -f whitening_top.f -o tb_whitening_top && ./obj_dir/tb_whitening_top > sim.log 2>&1
cat sim.log
grep -q "=== PASS ===" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
